/* Makefile */
# Verilator simulation of the GPS correlator channel.

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module channel_tb \
		-f flist.f -o channel_sim
	./obj_dir/channel_sim | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/corr_pkg.sv */
package corr_pkg;

   // Baseband input sample.
   localparam int SAMPLE_WIDTH = 3;
   typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

   // Local carrier, only +-1 and +-2 occur.
   typedef logic signed [SAMPLE_WIDTH-1:0] carrier_t;

   // Carrier NCO phase and its per-sample increment.
   localparam int PHASE_WIDTH = 32;
   typedef logic [PHASE_WIDTH-1:0] phase_t;

   // Top phase bits used as carrier table index.
   localparam int TABLE_BITS = 3;

   localparam int ACC_WIDTH = 20;
   typedef logic signed [ACC_WIDTH-1:0] acc_t;
   typedef logic [ACC_WIDTH-1:0] mag_t;
   typedef logic [2*ACC_WIDTH-1:0] power_t;

   typedef struct packed {
      acc_t i;
      acc_t q;
   } iq_acc_s;

   // Code chip per tap, 1 is +1 and 0 is -1.
   typedef struct packed {
      logic early;
      logic prompt;
      logic late;
   } code_taps_s;

   typedef struct packed {
      power_t early;
      power_t prompt;
      power_t late;
   } power_set_s;

   typedef enum logic [1:0] {TAP_EARLY, TAP_PROMPT, TAP_LATE} tap_e;

   typedef enum logic [1:0] {PWR_IDLE, PWR_SQUARE, PWR_DRAIN} power_state_e;

   localparam carrier_t COS_TABLE [0:2**TABLE_BITS-1] = '{
      3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1, 3'sd1, 3'sd2
   };

   localparam carrier_t SIN_TABLE [0:2**TABLE_BITS-1] = '{
      3'sd1, 3'sd2, 3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1
   };

endpackage

/* correlator/correlator_arm.sv */
module correlator_arm (
   input  logic                clk,
   input  logic                i_reset,
   input  logic                i_sample_valid,
   input  corr_pkg::sample_t   i_sample,
   input  corr_pkg::carrier_t  i_carrier_i,
   input  corr_pkg::carrier_t  i_carrier_q,
   input  logic                i_code_bit,
   input  logic                i_dump,
   output corr_pkg::iq_acc_s   o_acc
);

   import corr_pkg::*;

   // Sample times carrier spans -8..8.
   localparam int PROD_WIDTH = 2*SAMPLE_WIDTH - 1;

   logic signed [PROD_WIDTH-1:0] prod_i;
   logic signed [PROD_WIDTH-1:0] prod_q;
   acc_t                         contrib_i;
   acc_t                         contrib_q;
   acc_t                         acc_i;
   acc_t                         acc_q;

   assign prod_i = PROD_WIDTH'(i_sample) * PROD_WIDTH'(i_carrier_i);
   assign prod_q = PROD_WIDTH'(i_sample) * PROD_WIDTH'(i_carrier_q);

   // Code chip 0 flips the sign.
   always_comb begin
      if (i_code_bit) begin
         contrib_i = acc_t'(prod_i);
         contrib_q = acc_t'(prod_q);
      end else begin
         contrib_i = -acc_t'(prod_i);
         contrib_q = -acc_t'(prod_q);
      end
   end

   // A sample in the dump cycle starts the next block.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         acc_i <= '0;
         acc_q <= '0;
      end else if (i_dump) begin
         acc_i <= i_sample_valid ? contrib_i : '0;
         acc_q <= i_sample_valid ? contrib_q : '0;
      end else if (i_sample_valid) begin
         acc_i <= acc_i + contrib_i;
         acc_q <= acc_q + contrib_q;
      end
   end

   assign o_acc.i = acc_i;
   assign o_acc.q = acc_q;

endmodule

/* correlator/dump_control.sv */
module dump_control #(
   parameter int DUMP_LENGTH = 1023
) (
   input  logic clk,
   input  logic i_reset,
   input  logic i_sample_valid,
   output logic o_dump
);

   localparam int COUNT_WIDTH = $clog2(DUMP_LENGTH);

   logic [COUNT_WIDTH-1:0] count;
   logic                   last_sample;

   assign last_sample = count == COUNT_WIDTH'(DUMP_LENGTH - 1);

   // Count valid samples, wrap at end of block.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         count  <= '0;
         o_dump <= 1'b0;
      end else begin
         o_dump <= i_sample_valid && last_sample;
         if (i_sample_valid) begin
            count <= last_sample ? '0 : count + 1'b1;
         end
      end
   end

   // Shorter blocks would overrun the power pipeline.
   initial begin
      assert (DUMP_LENGTH >= 8)
         else $fatal(1, "DUMP_LENGTH %0d is below 8", DUMP_LENGTH);
   end

   a_dump_single: assert property (
      @(posedge clk) disable iff (i_reset)
      o_dump |=> !o_dump
   ) else $error("dump strobe high on two consecutive cycles");

endmodule

/* flist.f */
common/corr_pkg.sv
source/carrier_nco.sv
correlator/dump_control.sv
correlator/correlator_arm.sv
power/power_pipeline.sv
source/channel_top.sv
sim/channel_tb.sv

/* power/power_pipeline.sv */
module power_pipeline (
   input  logic                 clk,
   input  logic                 i_reset,
   input  logic                 i_dump,
   input  corr_pkg::iq_acc_s    i_acc_early,
   input  corr_pkg::iq_acc_s    i_acc_prompt,
   input  corr_pkg::iq_acc_s    i_acc_late,
   output logic                 o_power_valid,
   output corr_pkg::power_set_s o_power
);

   import corr_pkg::*;

   power_state_e state;
   tap_e         sel;
   tap_e         sq_sel;
   tap_e         sum_sel;
   logic         sq_valid;
   logic         sum_valid;
   mag_t         mag_i [0:2];
   mag_t         mag_q [0:2];
   power_t       sq_i;
   power_t       sq_q;
   power_t       sum;

   function automatic mag_t abs_val(input acc_t value);
      if (value[ACC_WIDTH-1]) begin
         return mag_t'(-value);
      end
      return mag_t'(value);
   endfunction

   // Magnitudes of all taps at the dump.
   always_ff @(posedge clk) begin
      if (i_dump) begin
         mag_i[TAP_EARLY]  <= abs_val(i_acc_early.i);
         mag_q[TAP_EARLY]  <= abs_val(i_acc_early.q);
         mag_i[TAP_PROMPT] <= abs_val(i_acc_prompt.i);
         mag_q[TAP_PROMPT] <= abs_val(i_acc_prompt.q);
         mag_i[TAP_LATE]   <= abs_val(i_acc_late.i);
         mag_q[TAP_LATE]   <= abs_val(i_acc_late.q);
      end
   end

   // One tap per cycle through the squarer.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         state <= PWR_IDLE;
         sel   <= TAP_EARLY;
      end else begin
         case (state)
            PWR_IDLE: begin
               if (i_dump) begin
                  state <= PWR_SQUARE;
                  sel   <= TAP_EARLY;
               end
            end
            PWR_SQUARE: begin
               case (sel)
                  TAP_EARLY:  sel <= TAP_PROMPT;
                  TAP_PROMPT: sel <= TAP_LATE;
                  default:    state <= PWR_DRAIN;
               endcase
            end
            PWR_DRAIN: begin
               if (sum_valid && sum_sel == TAP_LATE) begin
                  state <= PWR_IDLE;
               end
            end
            default: state <= PWR_IDLE;
         endcase
      end
   end

   // Tap select follows its data down the pipe.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         sq_valid  <= 1'b0;
         sum_valid <= 1'b0;
         sq_sel    <= TAP_EARLY;
         sum_sel   <= TAP_EARLY;
      end else begin
         sq_valid  <= state == PWR_SQUARE;
         sum_valid <= sq_valid;
         sq_sel    <= sel;
         sum_sel   <= sq_sel;
      end
   end

   always_ff @(posedge clk) begin
      if (state == PWR_SQUARE) begin
         sq_i <= power_t'(mag_i[sel]) * power_t'(mag_i[sel]);
         sq_q <= power_t'(mag_q[sel]) * power_t'(mag_q[sel]);
      end
      if (sq_valid) begin
         sum <= sq_i + sq_q;
      end
   end

   // Results land in their own slot.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_power       <= '0;
         o_power_valid <= 1'b0;
      end else begin
         o_power_valid <= sum_valid && sum_sel == TAP_LATE;
         if (sum_valid) begin
            case (sum_sel)
               TAP_EARLY:  o_power.early  <= sum;
               TAP_PROMPT: o_power.prompt <= sum;
               default:    o_power.late   <= sum;
            endcase
         end
      end
   end

   a_dump_idle: assert property (
      @(posedge clk) disable iff (i_reset)
      i_dump |-> state == PWR_IDLE
   ) else $error("dump arrived while power pipeline busy");

   // Fixed latency from dump to result.
   a_dump_latency: assert property (
      @(posedge clk) disable iff (i_reset)
      i_dump |-> ##6 o_power_valid
   ) else $error("power valid not 6 cycles after dump");

endmodule

/* sim/channel_tb.sv */
module channel_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import corr_pkg::*;

   localparam int DUMP_LENGTH = 16;
   localparam int MAX_BLOCKS = 64;
   localparam int DRAIN_LIMIT = 200;

   // Carrier values per top three phase bits.
   localparam int COS_REF [0:7] = '{2, 1, -1, -2, -2, -1, 1, 2};
   localparam int SIN_REF [0:7] = '{1, 2, 2, 1, -1, -2, -2, -1};

   logic       clk;
   logic       i_reset;
   logic       i_sample_valid;
   sample_t    i_sample;
   code_taps_s i_code;
   phase_t     i_phase_inc;
   logic       o_power_valid;
   power_set_s o_power;

   integer     seed;
   phase_t     model_phase;
   int         model_count;
   int         sum_i [0:2];
   int         sum_q [0:2];
   power_set_s expected_mem [0:MAX_BLOCKS-1];
   int         write_idx = 0;
   int         read_idx = 0;
   int         errors = 0;
   logic       block_end_flag;
   logic       const_check;
   logic       sign_check;
   logic       timed_out;

   channel_top #(
      .DUMP_LENGTH (DUMP_LENGTH)
   ) dut (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_sample_valid (i_sample_valid),
      .i_sample       (i_sample),
      .i_code         (i_code),
      .i_phase_inc    (i_phase_inc),
      .o_power_valid  (o_power_valid),
      .o_power        (o_power)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      if (!i_reset && o_power_valid) begin
         read_idx <= read_idx + 1;
      end
   end

   task automatic report_mismatch(input string msg);
      errors++;
      $display("FAILED %0t: %s, got %h", $time, msg, o_power);
   endtask

   function automatic power_t tap_power(input int si, input int sq);
      longint p;
      p = longint'(si) * si + longint'(sq) * sq;
      return power_t'(p);
   endfunction

   function automatic sample_t random_sample();
      int r;
      r = $random(seed);
      return sample_t'(r[2:0]);
   endfunction

   function automatic code_taps_s random_code();
      int r;
      r = $random(seed);
      return code_taps_s'(r[2:0]);
   endfunction

   // Reference correlation of one valid sample.
   task automatic model_sample(input sample_t s, input code_taps_s c, input phase_t inc,
                               output logic block_end);
      int         idx;
      int         sign [0:2];
      power_set_s expected;
      idx = int'(model_phase[31:29]);
      sign[0] = c.early ? 1 : -1;
      sign[1] = c.prompt ? 1 : -1;
      sign[2] = c.late ? 1 : -1;
      for (int k = 0; k < 3; k++) begin
         sum_i[k] += int'(s) * COS_REF[idx] * sign[k];
         sum_q[k] += int'(s) * SIN_REF[idx] * sign[k];
      end
      model_phase = model_phase + inc;
      model_count++;
      block_end = model_count == DUMP_LENGTH;
      if (block_end) begin
         expected.early  = tap_power(sum_i[0], sum_q[0]);
         expected.prompt = tap_power(sum_i[1], sum_q[1]);
         expected.late   = tap_power(sum_i[2], sum_q[2]);
         expected_mem[write_idx] = expected;
         write_idx++;
         model_count = 0;
         for (int k = 0; k < 3; k++) begin
            sum_i[k] = 0;
            sum_q[k] = 0;
         end
      end
   endtask

   // Idle cycles carry junk that must be ignored.
   task automatic send_sample(input sample_t s, input code_taps_s c, input phase_t inc,
                              input int gap);
      logic block_end;
      @(posedge clk);
      i_sample_valid <= 1'b1;
      i_sample       <= s;
      i_code         <= c;
      i_phase_inc    <= inc;
      model_sample(s, c, inc, block_end);
      block_end_flag <= block_end;
      for (int n = 0; n < gap; n++) begin
         @(posedge clk);
         i_sample_valid <= 1'b0;
         block_end_flag <= 1'b0;
         i_sample       <= random_sample();
         i_code         <= random_code();
         i_phase_inc    <= phase_t'($random(seed));
      end
   endtask

   task automatic idle_cycles(input int n);
      for (int k = 0; k < n; k++) begin
         @(posedge clk);
         i_sample_valid <= 1'b0;
         block_end_flag <= 1'b0;
      end
   endtask

   task automatic drain_results();
      int cycles;
      cycles = 0;
      idle_cycles(1);
      while (read_idx != write_idx && cycles < DRAIN_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (read_idx != write_idx) begin
         $display("Timeout: %0d power results never arrived", write_idx - read_idx);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic run_constant_block();
      const_check = 1'b1;
      for (int n = 0; n < 2 * DUMP_LENGTH; n++) begin
         send_sample(3'sd3, code_taps_s'(3'b111), '0, 0);
      end
      drain_results();
      const_check = 1'b0;
   endtask

   task automatic run_sign_block();
      code_taps_s c;
      sign_check = 1'b1;
      for (int n = 0; n < 2 * DUMP_LENGTH; n++) begin
         c.early  = 1'b0;
         c.prompt = 1'b1;
         c.late   = n[0];
         send_sample(-3'sd2, c, '0, 0);
      end
      drain_results();
      sign_check = 1'b0;
   endtask

   task automatic run_random_blocks(input int blocks, input logic rotate, input int gap_mask,
                                    input logic rare_gap);
      phase_t inc;
      int     gap;
      for (int n = 0; n < blocks * DUMP_LENGTH; n++) begin
         inc = rotate ? 32'h2000_0000 : phase_t'($random(seed));
         gap = $random(seed) & gap_mask;
         if (rare_gap) begin
            gap = gap == 0 ? 1 : 0;
         end
         send_sample(random_sample(), random_code(), inc, gap);
      end
      drain_results();
   endtask

   initial begin
      seed           = 32'hf016_2e1e;
      model_phase    = '0;
      model_count    = 0;
      for (int k = 0; k < 3; k++) begin
         sum_i[k] = 0;
         sum_q[k] = 0;
      end
      const_check    = 1'b0;
      sign_check     = 1'b0;
      timed_out      = 1'b0;
      block_end_flag = 1'b0;
      i_reset        = 1'b1;
      i_sample_valid = 1'b0;
      i_sample       = '0;
      i_code         = '0;
      i_phase_inc    = '0;
      repeat (8) @(posedge clk);
      i_reset <= 1'b0;
      idle_cycles(6);
      // Zero increment keeps the phase at index 0 for the directed blocks.
      run_constant_block();
      if (!timed_out) run_sign_block();
      if (!timed_out) run_random_blocks(4, 1'b1, 0, 1'b0);
      if (!timed_out) run_random_blocks(6, 1'b0, 7, 1'b1);
      if (!timed_out) run_random_blocks(4, 1'b0, 7, 1'b0);
      $display("Errors: %0d, blocks checked: %0d of %0d", errors, read_idx, write_idx);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   a_idle_zero: assert property (
      @(posedge clk) disable iff (i_reset)
      write_idx == 0 |-> !o_power_valid && o_power == '0
   ) else report_mismatch("output not idle before first block");

   a_power_value: assert property (
      @(posedge clk) disable iff (i_reset)
      o_power_valid |-> read_idx < write_idx && o_power == expected_mem[read_idx]
   ) else report_mismatch("power set differs from model");

   a_latency: assert property (
      @(posedge clk) disable iff (i_reset)
      block_end_flag |-> ##7 o_power_valid
   ) else report_mismatch("power valid missing 7 cycles after last sample");

   // Exactly one valid per block.
   a_single_valid: assert property (
      @(posedge clk) disable iff (i_reset)
      o_power_valid |-> $past(block_end_flag, 7)
   ) else report_mismatch("power valid without a finished block");

   a_constant_power: assert property (
      @(posedge clk) disable iff (i_reset)
      const_check && o_power_valid |->
         o_power.early == 40'd11520 && o_power.prompt == 40'd11520 &&
         o_power.late == 40'd11520
   ) else report_mismatch("constant block power is not 11520");

   a_tap_sign: assert property (
      @(posedge clk) disable iff (i_reset)
      sign_check && o_power_valid |-> o_power.early == o_power.prompt && o_power.late == '0
   ) else report_mismatch("tap sign or independence broken");

endmodule

/* source/carrier_nco.sv */
module carrier_nco (
   input  logic               clk,
   input  logic               i_reset,
   input  logic               i_advance,
   input  corr_pkg::phase_t   i_phase_inc,
   output corr_pkg::carrier_t o_carrier_i,
   output corr_pkg::carrier_t o_carrier_q
);

   import corr_pkg::*;

   phase_t                phase;
   logic [TABLE_BITS-1:0] table_index;

   // Phase steps once per valid sample.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase <= '0;
      end else if (i_advance) begin
         phase <= phase + i_phase_inc;
      end
   end

   assign table_index = phase[PHASE_WIDTH-1 -: TABLE_BITS];

   // Carrier comes straight from the current phase.
   assign o_carrier_i = COS_TABLE[table_index];
   assign o_carrier_q = SIN_TABLE[table_index];

endmodule

/* source/channel_top.sv */
module channel_top #(
   parameter int DUMP_LENGTH = 1023
) (
   input  logic                 clk,
   input  logic                 i_reset,
   input  logic                 i_sample_valid,
   input  corr_pkg::sample_t    i_sample,
   input  corr_pkg::code_taps_s i_code,
   input  corr_pkg::phase_t     i_phase_inc,
   output logic                 o_power_valid,
   output corr_pkg::power_set_s o_power
);

   import corr_pkg::*;

   carrier_t carrier_i;
   carrier_t carrier_q;
   logic     dump;
   iq_acc_s  acc_early;
   iq_acc_s  acc_prompt;
   iq_acc_s  acc_late;

   carrier_nco nco (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_advance   (i_sample_valid),
      .i_phase_inc (i_phase_inc),
      .o_carrier_i (carrier_i),
      .o_carrier_q (carrier_q)
   );

   dump_control #(
      .DUMP_LENGTH (DUMP_LENGTH)
   ) dump_ctrl (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_sample_valid (i_sample_valid),
      .o_dump         (dump)
   );

   correlator_arm arm_early (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_sample_valid (i_sample_valid),
      .i_sample       (i_sample),
      .i_carrier_i    (carrier_i),
      .i_carrier_q    (carrier_q),
      .i_code_bit     (i_code.early),
      .i_dump         (dump),
      .o_acc          (acc_early)
   );

   correlator_arm arm_prompt (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_sample_valid (i_sample_valid),
      .i_sample       (i_sample),
      .i_carrier_i    (carrier_i),
      .i_carrier_q    (carrier_q),
      .i_code_bit     (i_code.prompt),
      .i_dump         (dump),
      .o_acc          (acc_prompt)
   );

   correlator_arm arm_late (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_sample_valid (i_sample_valid),
      .i_sample       (i_sample),
      .i_carrier_i    (carrier_i),
      .i_carrier_q    (carrier_q),
      .i_code_bit     (i_code.late),
      .i_dump         (dump),
      .o_acc          (acc_late)
   );

   power_pipeline power (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_dump        (dump),
      .i_acc_early   (acc_early),
      .i_acc_prompt  (acc_prompt),
      .i_acc_late    (acc_late),
      .o_power_valid (o_power_valid),
      .o_power       (o_power)
   );

endmodule
